/* ref_mem_ctrl.f */
src/ref_mem_pkg.sv
src/ref_phase_ctrl.sv
src/ref_preload_writer.sv
src/ref_search_reader.sv
src/ref_bank_port.sv
src/ref_mem_ctrl.sv
tb/ref_mem_ctrl_assertions.sv
tb/ref_mem_ctrl_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module ref_mem_ctrl_tb \
	-f ref_mem_ctrl.f \
	-o ref_mem_ctrl_sim

out=$(./obj_dir/ref_mem_ctrl_sim 2>&1) || true
echo "$out"
echo "$out" | grep -qx "Done: no errors"

/* tb/ref_mem_ctrl_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ref_mem_ctrl_tb
	import ref_mem_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int RUNS = 4;
	localparam int WATCHDOG_CYCLES = RUNS * 1400 + 100;
	localparam int WR_TOTAL = (NUM_BANKS / BANK_GROUP) * ROWS_PER_GROUP;
	localparam int RD_TOTAL = PRIME_ROWS
		+ SEARCH_COLS * 2 * (HALF_ROWS + STALL_HI - STALL_LO + 1);
	// every output cycle of a run, priming reads share their cycle with writes
	localparam int BUSY_TOTAL = WR_TOTAL + RD_TOTAL - PRIME_ROWS;

	logic clk;
	logic rst_n;
	logic begin_prepare;
	logic busy;
	logic [NUM_BANKS-1:0] bank_sel;
	bank_addr_bus_t wr_addr;
	logic rd_en;
	bank_addr_bus_t rd_addr;
	logic [4:0] shift_value;

	logic [NUM_BANKS-1:0] exp_sel [WR_TOTAL];
	bank_addr_bus_t exp_wr_addr [WR_TOTAL];
	bank_addr_bus_t exp_rd_addr [RD_TOTAL];
	logic [4:0] exp_shift [RD_TOTAL];

	int seed;
	int wr_idx;
	int rd_idx;
	int busy_cycles;
	int wr_errors;
	int rd_errors;
	int bit_errors;
	int count_errors;
	logic in_run;

	ref_mem_ctrl #(
		.NUM_BANKS(NUM_BANKS),
		.ROWS_PER_GROUP(ROWS_PER_GROUP)
	) dut (
		.clk(clk),
		.rst_n(rst_n),
		.begin_prepare(begin_prepare),
		.busy(busy),
		.bank_sel(bank_sel),
		.wr_addr(wr_addr),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.shift_value(shift_value)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// banks below split see the row one block further down
	function automatic bank_addr_bus_t spread_rows(input int row, input int split);
		bank_addr_bus_t bus;
		for (int b = 0; b < NUM_BANKS; b++) begin
			bus[b] = (b < split) ? bank_addr_t'(row + BLOCK_STRIDE) : bank_addr_t'(row);
		end
		return bus;
	endfunction

	task automatic build_model;
		logic [NUM_BANKS-1:0] ones;
		int n;
		int row;
		int split;
		int reps;
		ones = NUM_BANKS'(2 ** BANK_GROUP - 1);
		n = 0;
		for (int k = 0; k < WR_TOTAL; k++) begin
			exp_sel[k] = ones << (BANK_GROUP * (k / ROWS_PER_GROUP));
			exp_wr_addr[k] = spread_rows(k % ROWS_PER_GROUP, 0);
		end
		for (int p = 0; p < PRIME_ROWS; p++) begin
			exp_rd_addr[n] = spread_rows(p, 0);
			exp_shift[n] = 5'd0;
			n++;
		end
		for (int c = 1; c <= SEARCH_COLS; c++) begin
			for (int h = 0; h < 2; h++) begin
				for (int r = 0; r < HALF_ROWS; r++) begin
					reps = (r >= STALL_LO && r <= STALL_HI) ? 2 : 1;
					row = r + BLOCK_STRIDE * ((c - 1) / 4) + BLOCK_STRIDE * h;
					split = SPLIT_STEP * ((c - 1) % 4);
					for (int i = 0; i < reps; i++) begin
						exp_rd_addr[n] = spread_rows(row, split);
						exp_shift[n] = 5'(split);
						n++;
					end
				end
			end
		end
	endtask

	task automatic check_wr(input logic [NUM_BANKS-1:0] sel_got,
			input logic [NUM_BANKS-1:0] sel_exp,
			input bank_addr_bus_t addr_got, input bank_addr_bus_t addr_exp);
		if (sel_got !== sel_exp) begin
			wr_errors++;
			$display("Fail %0t ns: bank_sel got %h expected %h", $time, sel_got, sel_exp);
		end
		if (addr_got !== addr_exp) begin
			wr_errors++;
			$display("Fail %0t ns: wr_addr got %h expected %h", $time, addr_got, addr_exp);
		end
	endtask

	task automatic check_rd(input bank_addr_bus_t addr_got, input bank_addr_bus_t addr_exp,
			input logic [4:0] shift_got, input logic [4:0] shift_exp);
		if (addr_got !== addr_exp) begin
			rd_errors++;
			$display("Fail %0t ns: rd_addr got %h expected %h", $time, addr_got, addr_exp);
		end
		if (shift_got !== shift_exp) begin
			rd_errors++;
			$display("Fail %0t ns: shift_value got %0d expected %0d",
				$time, shift_got, shift_exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			bit_errors++;
			$display("Fail %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// output monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (!in_run) begin
				check_bit("busy", busy, 1'b0);
				check_bit("bank_sel idle", bank_sel == '0, 1'b1);
				check_bit("rd_en", rd_en, 1'b0);
			end else begin
				if (busy) begin
					busy_cycles++;
				end
				if (bank_sel != '0) begin
					if (wr_idx < WR_TOTAL) begin
						check_wr(bank_sel, exp_sel[wr_idx], wr_addr, exp_wr_addr[wr_idx]);
					end
					wr_idx++;
				end
				if (rd_en) begin
					if (rd_idx < RD_TOTAL) begin
						check_rd(rd_addr, exp_rd_addr[rd_idx], shift_value, exp_shift[rd_idx]);
						check_bit("write with read", bank_sel != '0, rd_idx < PRIME_ROWS);
						if (rd_idx < PRIME_ROWS) begin
							// priming lines up with the last preload writes
							check_bit("priming at end of preload",
								wr_idx == WR_TOTAL - PRIME_ROWS + rd_idx + 1, 1'b1);
						end
					end
					rd_idx++;
				end
			end
		end
	end

	task automatic do_run(input int run);
		int gap;
		gap = $unsigned($random(seed)) % 21;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
		wr_idx = 0;
		rd_idx = 0;
		busy_cycles = 0;
		in_run = 1'b1;
		begin_prepare = 1'b1;
		@(posedge clk);
		#1;
		begin_prepare = 1'b0;
		@(posedge clk);
		#1;
		check_bit("busy", busy, 1'b1);
		// stray starts while busy must be ignored
		while (busy) begin
			begin_prepare = (($random(seed) & 7) == 0);
			@(posedge clk);
			#1;
		end
		begin_prepare = 1'b0;
		in_run = 1'b0;
		if (wr_idx != WR_TOTAL) begin
			count_errors++;
			$display("run %0d gave %0d writes instead of %0d", run, wr_idx, WR_TOTAL);
		end
		if (rd_idx != RD_TOTAL) begin
			count_errors++;
			$display("run %0d gave %0d reads instead of %0d", run, rd_idx, RD_TOTAL);
		end
		if (busy_cycles != BUSY_TOTAL) begin
			count_errors++;
			$display("run %0d held busy for %0d cycles instead of %0d",
				run, busy_cycles, BUSY_TOTAL);
		end
	endtask

	initial begin
		seed = 32'h64e1_9df0;
		rst_n = 1'b0;
		begin_prepare = 1'b0;
		in_run = 1'b0;
		wr_idx = 0;
		rd_idx = 0;
		busy_cycles = 0;
		wr_errors = 0;
		rd_errors = 0;
		bit_errors = 0;
		count_errors = 0;
		build_model();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (3) begin
			@(posedge clk);
			#1;
			check_bit("shift_value zero", shift_value == 5'd0, 1'b1);
		end
		for (int run = 0; run < RUNS; run++) begin
			do_run(run);
		end
		$display("errors: write %0d, read %0d, level %0d, count %0d, assertion %0d",
			wr_errors, rd_errors, bit_errors, count_errors, dut.u_assertions.fail_count);
		if (wr_errors + rd_errors + bit_errors + count_errors
				+ dut.u_assertions.fail_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: runs did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/ref_mem_ctrl_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module ref_mem_ctrl_assertions
	import ref_mem_pkg::*;
#(
	parameter int NUM_BANKS = ref_mem_pkg::NUM_BANKS
) (
	input logic clk,
	input logic rst_n,
	input logic busy,
	input logic [NUM_BANKS-1:0] bank_sel,
	input logic rd_en,
	input logic [4:0] shift_value
);

	// assertion failures so far
	int fail_count = 0;

	// zero, or exactly one aligned group of banks
	function automatic logic group_sel_ok(input logic [NUM_BANKS-1:0] sel);
		logic ok;
		logic [NUM_BANKS-1:0] ones;
		ones = NUM_BANKS'(2 ** BANK_GROUP - 1);
		ok = (sel == '0);
		for (int g = 0; g < NUM_BANKS / BANK_GROUP; g++) begin
			if (sel == (ones << (g * BANK_GROUP))) begin
				ok = 1'b1;
			end
		end
		return ok;
	endfunction

	sel_group: assert property (@(posedge clk) disable iff (!rst_n)
		group_sel_ok(bank_sel))
		else begin
			fail_count++;
			$error("bank_sel is not a single aligned bank group");
		end

	shift_step: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en |-> (shift_value[2:0] == 3'd0))
		else begin
			fail_count++;
			$error("shift_value is not a multiple of the split step");
		end

	idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> (!rd_en && (bank_sel == '0)))
		else begin
			fail_count++;
			$error("bank access while not busy");
		end

endmodule

bind ref_mem_ctrl ref_mem_ctrl_assertions #(
	.NUM_BANKS(NUM_BANKS)
) u_assertions (
	.clk(clk),
	.rst_n(rst_n),
	.busy(busy),
	.bank_sel(bank_sel),
	.rd_en(rd_en),
	.shift_value(shift_value)
);

`default_nettype wire

/* src/ref_mem_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module ref_mem_ctrl
	import ref_mem_pkg::*;
#(
	parameter int NUM_BANKS = ref_mem_pkg::NUM_BANKS,
	parameter int ROWS_PER_GROUP = ref_mem_pkg::ROWS_PER_GROUP
) (
	input logic clk,
	input logic rst_n,
	input logic begin_prepare,
	output logic busy,
	output logic [NUM_BANKS-1:0] bank_sel,
	output bank_addr_bus_t wr_addr,
	output logic rd_en,
	output bank_addr_bus_t rd_addr,
	output logic [4:0] shift_value
);

	phase_t phase;
	logic pre_done;
	logic search_done;
	wr_cmd_t pre_wr;
	rd_cmd_t pre_rd;
	rd_cmd_t srch_rd;

	ref_phase_ctrl u_phase_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.begin_prepare(begin_prepare),
		.pre_done(pre_done),
		.search_done(search_done),
		.phase(phase),
		.busy(busy)
	);

	ref_preload_writer #(
		.NUM_BANKS(NUM_BANKS),
		.ROWS_PER_GROUP(ROWS_PER_GROUP)
	) u_preload_writer (
		.clk(clk),
		.rst_n(rst_n),
		.phase(phase),
		.pre_wr(pre_wr),
		.pre_rd(pre_rd),
		.pre_done(pre_done)
	);

	ref_search_reader u_search_reader (
		.clk(clk),
		.rst_n(rst_n),
		.phase(phase),
		.srch_rd(srch_rd),
		.search_done(search_done)
	);

	ref_bank_port #(
		.NUM_BANKS(NUM_BANKS)
	) u_bank_port (
		.clk(clk),
		.rst_n(rst_n),
		.pre_wr(pre_wr),
		.pre_rd(pre_rd),
		.srch_rd(srch_rd),
		.bank_sel(bank_sel),
		.wr_addr(wr_addr),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.shift_value(shift_value)
	);

endmodule

`default_nettype wire

/* src/ref_bank_port.sv */
`timescale 1ns/1ns
`default_nettype none

module ref_bank_port
	import ref_mem_pkg::*;
#(
	parameter int NUM_BANKS = ref_mem_pkg::NUM_BANKS
) (
	input logic clk,
	input logic rst_n,
	input wr_cmd_t pre_wr,
	input rd_cmd_t pre_rd,
	input rd_cmd_t srch_rd,
	output logic [NUM_BANKS-1:0] bank_sel,
	output bank_addr_bus_t wr_addr,
	output logic rd_en,
	output bank_addr_bus_t rd_addr,
	output logic [4:0] shift_value
);

	rd_cmd_t rd;
	logic [NUM_BANKS-1:0] sel_d;
	bank_addr_t row_far;

	// the two read sources never overlap
	assign rd = pre_rd.valid ? pre_rd : srch_rd;
	assign row_far = rd.row + bank_addr_t'(BLOCK_STRIDE);

	// one group of adjacent banks per write
	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			sel_d[b] = pre_wr.valid && ((b / BANK_GROUP) == int'(pre_wr.group));
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bank_sel <= '0;
			rd_en <= 1'b0;
			shift_value <= '0;
		end else begin
			bank_sel <= sel_d;
			rd_en <= rd.valid;
			if (rd.valid) begin
				shift_value <= rd.split;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pre_wr.valid) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				wr_addr[b] <= pre_wr.row;
			end
		end
		if (rd.valid) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				rd_addr[b] <= (b < int'(rd.split)) ? row_far : rd.row;
			end
		end
	end

endmodule

`default_nettype wire

/* src/ref_search_reader.sv */
`timescale 1ns/1ns
`default_nettype none

module ref_search_reader
	import ref_mem_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input phase_t phase,
	output rd_cmd_t srch_rd,
	output logic search_done
);

	localparam bank_addr_t STRIDE = bank_addr_t'(BLOCK_STRIDE);

	logic [4:0] row_cnt;
	logic stall;
	logic half;
	// column minus one, 0 to SEARCH_COLS-1
	logic [2:0] col_idx;

	logic active;
	logic in_stall;
	logic row_last;
	logic last_cmd;
	bank_addr_t row_addr;

	assign active = (phase == PH_SEARCH);
	assign in_stall = (row_cnt >= 5'(STALL_LO)) && (row_cnt <= 5'(STALL_HI));
	assign row_last = (row_cnt == 5'(HALF_ROWS - 1));
	assign last_cmd = active && row_last && half && (col_idx == 3'(SEARCH_COLS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_cnt <= '0;
			stall <= 1'b0;
			half <= 1'b0;
			col_idx <= '0;
		end else if (!active || last_cmd) begin
			row_cnt <= '0;
			stall <= 1'b0;
			half <= 1'b0;
			col_idx <= '0;
		end else if (in_stall && !stall) begin
			// hold the row for its second issue
			stall <= 1'b1;
		end else begin
			stall <= 1'b0;
			if (row_last) begin
				row_cnt <= '0;
				half <= ~half;
				if (half) begin
					col_idx <= col_idx + 3'd1;
				end
			end else begin
				row_cnt <= row_cnt + 5'd1;
			end
		end
	end

	always_comb begin
		row_addr = bank_addr_t'(row_cnt);
		// columns 5 to 7 sit one block further down
		if (col_idx[2]) begin
			row_addr = row_addr + STRIDE;
		end
		// lower block pair
		if (half) begin
			row_addr = row_addr + STRIDE;
		end
	end

	always_comb begin
		srch_rd.valid = active;
		srch_rd.row = row_addr;
		srch_rd.split = 5'(col_idx[1:0] * SPLIT_STEP);
	end

	assign search_done = last_cmd;

endmodule

`default_nettype wire

/* src/ref_preload_writer.sv */
`timescale 1ns/1ns
`default_nettype none

module ref_preload_writer
	import ref_mem_pkg::*;
#(
	parameter int NUM_BANKS = ref_mem_pkg::NUM_BANKS,
	parameter int ROWS_PER_GROUP = ref_mem_pkg::ROWS_PER_GROUP
) (
	input logic clk,
	input logic rst_n,
	input phase_t phase,
	output wr_cmd_t pre_wr,
	output rd_cmd_t pre_rd,
	output logic pre_done
);

	localparam int NUM_GROUPS = NUM_BANKS / BANK_GROUP;
	localparam int PRIME_FIRST = ROWS_PER_GROUP - PRIME_ROWS;

	// preload count k kept as group k / ROWS_PER_GROUP and row k mod ROWS_PER_GROUP
	logic [2:0] group_cnt;
	bank_addr_t row_cnt;
	logic active;
	logic row_last;
	logic group_last;
	logic priming;

	assign active = (phase == PH_PRELOAD);
	assign row_last = (row_cnt == bank_addr_t'(ROWS_PER_GROUP - 1));
	assign group_last = (group_cnt == 3'(NUM_GROUPS - 1));
	assign priming = group_last && (row_cnt >= bank_addr_t'(PRIME_FIRST));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			group_cnt <= '0;
			row_cnt <= '0;
		end else if (!active) begin
			group_cnt <= '0;
			row_cnt <= '0;
		end else if (row_last) begin
			row_cnt <= '0;
			group_cnt <= group_cnt + 3'd1;
		end else begin
			row_cnt <= row_cnt + bank_addr_t'(1);
		end
	end

	always_comb begin
		pre_wr.valid = active;
		pre_wr.group = group_cnt;
		pre_wr.row = row_cnt;
		// last few cycles also prime the PEs with rows 0 and up
		pre_rd.valid = active && priming;
		pre_rd.row = row_cnt - bank_addr_t'(PRIME_FIRST);
		pre_rd.split = '0;
	end

	assign pre_done = active && group_last && row_last;

endmodule

`default_nettype wire

/* src/ref_phase_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module ref_phase_ctrl
	import ref_mem_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic begin_prepare,
	input logic pre_done,
	input logic search_done,
	output phase_t phase,
	output logic busy
);

	phase_t phase_nxt;

	always_comb begin
		phase_nxt = phase;
		case (phase)
			PH_IDLE: begin
				// start only once busy has dropped
				if (begin_prepare && !busy) begin
					phase_nxt = PH_PRELOAD;
				end
			end
			PH_PRELOAD: begin
				if (pre_done) begin
					phase_nxt = PH_SEARCH;
				end
			end
			PH_SEARCH: begin
				if (search_done) begin
					phase_nxt = PH_IDLE;
				end
			end
			default: begin
				phase_nxt = PH_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
			busy <= 1'b0;
		end else begin
			phase <= phase_nxt;
			// trails phase by one cycle to cover the output register
			busy <= (phase != PH_IDLE);
		end
	end

endmodule

`default_nettype wire

/* src/ref_mem_pkg.sv */
`default_nettype none

package ref_mem_pkg;

	// bank geometry
	parameter int NUM_BANKS = 32;
	parameter int ADDR_W = 7;
	parameter int BANK_GROUP = 4;

	// preload window
	parameter int ROWS_PER_GROUP = 96;
	parameter int PRIME_ROWS = 4;

	// sub-area 1 walk
	parameter int SEARCH_COLS = 7;
	parameter int HALF_ROWS = 24;
	parameter int BLOCK_STRIDE = 24;
	parameter int STALL_LO = 7;
	parameter int STALL_HI = 19;
	parameter int SPLIT_STEP = 8;

	typedef logic [ADDR_W-1:0] bank_addr_t;
	typedef bank_addr_t [NUM_BANKS-1:0] bank_addr_bus_t;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_PRELOAD,
		PH_SEARCH
	} phase_t;

	// write one row into a group of four banks
	typedef struct packed {
		logic valid;
		logic [2:0] group;
		bank_addr_t row;
	} wr_cmd_t;

	// banks below split read row + BLOCK_STRIDE, the rest read row
	typedef struct packed {
		logic valid;
		bank_addr_t row;
		logic [4:0] split;
	} rd_cmd_t;

endpackage

`default_nettype wire
